//--- flist.f
usb_pkg.sv
bit_stream_if.sv
usb_pkt_serializer.sv
usb_crc_append.sv
usb_bit_stuffer.sv
usb_line_driver.sv
usb_tx_top.sv
tb_usb_tx_assert.sv
tb_usb_tx.sv

//--- run.sh
#!/bin/sh
# build and run the USB transmit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_usb_tx -f flist.f -o sim_usb_tx
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_usb_tx > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "All tests passed" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- tb_usb_tx.sv
/*
 * Testbench for the USB transmit pipeline
 * Drives packets into the packet port, decodes D+/D- back to raw bits
 * and compares them with a bit model of SYNC, PID, body, CRC and stuffing
 */
`timescale 1ns/1ps
`default_nettype none

module tb_usb_tx;

  localparam int DATA_W  = 64;
  localparam int TIMEOUT = 500;
  localparam int EOP_LEN = usb_pkg::EOP_SE0_CYCLES + 1;

  logic                       clk;
  logic                       rst_L;
  logic                       pkt_valid;
  logic                       pkt_ready;
  usb_pkg::pid_e              pkt_pid;
  logic [usb_pkg::ADDR_W-1:0] pkt_addr;
  logic [usb_pkg::ENDP_W-1:0] pkt_endp;
  logic [DATA_W-1:0]          pkt_data;
  logic                       dp;
  logic                       dm;
  logic                       oe;

  int          checks;
  int          errors;
  int          timeouts;
  int          sent;
  int          pkts_done;
  int          accepts;
  logic [63:0] rng;

  // raw bits of every packet not yet seen on the line
  bit         exp_bits[$];
  int         exp_lens[$];
  int         exp_stuffs[$];
  logic [1:0] line_q[$];

  usb_tx_top #(
    .DATA_W (DATA_W)
  ) DUT (
    .clk       (clk),
    .rst_L     (rst_L),
    .pkt_valid (pkt_valid),
    .pkt_ready (pkt_ready),
    .pkt_pid   (pkt_pid),
    .pkt_addr  (pkt_addr),
    .pkt_endp  (pkt_endp),
    .pkt_data  (pkt_data),
    .dp        (dp),
    .dm        (dm),
    .oe        (oe)
  );

  bind usb_tx_top tb_usb_tx_assert u_assert (
    .clk       (clk),
    .rst_L     (rst_L),
    .pkt_valid (pkt_valid),
    .pkt_ready (pkt_ready),
    .pkt_pid   (pkt_pid),
    .dp        (dp),
    .dm        (dm),
    .oe        (oe)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("ERR %0t %s: got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  function automatic logic [63:0] xorshift(input logic [63:0] x);
    logic [63:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 7);
    y = y ^ (y << 17);
    return y;
  endfunction

  function automatic int crc_of(input bit body[$], input int width, input int poly,
                                input int init);
    int r;
    int fb;
    r = init;
    foreach (body[i]) begin
      fb = ((r >> (width - 1)) & 1) ^ int'(body[i]);
      r  = (r << 1) & ((1 << width) - 1);
      if (fb == 1)
        r = r ^ poly;
    end
    return r;
  endfunction

  // raw bits before stuffing, and how many zeros stuffing adds
  task automatic build_expected(input usb_pkg::pid_e pid,
                                input logic [usb_pkg::ADDR_W-1:0] addr,
                                input logic [usb_pkg::ENDP_W-1:0] endp,
                                input logic [DATA_W-1:0] data);
    logic [7:0] pid_bits;
    bit         body[$];
    bit         raw[$];
    int         crc;
    int         cw;
    int         ones;
    int         stuffs;
    pid_bits = pid;
    crc      = 0;
    cw       = 0;
    ones     = 0;
    stuffs   = 0;
    for (int i = 0; i < usb_pkg::SYNC_BITS; i++)
      raw.push_back(i == usb_pkg::SYNC_BITS - 1);
    for (int i = 0; i < 8; i++)
      raw.push_back(pid_bits[i]);
    if (pid == usb_pkg::PID_OUT || pid == usb_pkg::PID_IN) begin
      for (int i = 0; i < usb_pkg::ADDR_W; i++)
        body.push_back(addr[i]);
      for (int i = 0; i < usb_pkg::ENDP_W; i++)
        body.push_back(endp[i]);
      cw  = usb_pkg::CRC5_W;
      crc = crc_of(body, cw, int'(usb_pkg::CRC5_POLY), int'(usb_pkg::CRC5_INIT));
    end else if (pid == usb_pkg::PID_DATA0) begin
      for (int i = 0; i < DATA_W; i++)
        body.push_back(data[i]);
      cw  = usb_pkg::CRC16_W;
      crc = crc_of(body, cw, int'(usb_pkg::CRC16_POLY), int'(usb_pkg::CRC16_INIT));
    end
    foreach (body[i])
      raw.push_back(body[i]);
    // complemented CRC goes out MSB first
    for (int i = cw - 1; i >= 0; i--)
      raw.push_back(((crc >> i) & 1) == 0);
    for (int i = usb_pkg::SYNC_BITS; i < raw.size(); i++) begin
      ones = raw[i] ? ones + 1 : 0;
      if (ones == usb_pkg::STUFF_RUN) begin
        stuffs++;
        ones = 0;
      end
    end
    foreach (raw[i])
      exp_bits.push_back(raw[i]);
    exp_lens.push_back(raw.size());
    exp_stuffs.push_back(stuffs);
    sent++;
  endtask

  // NRZI-decode and unstuff one finished packet, then compare with the model
  task automatic check_packet();
    logic [1:0] smp[$];
    bit         got[$];
    bit         b;
    logic       prev;
    int         same;
    int         ones;
    int         stuffs;
    int         n;
    int         exp_len;
    smp = line_q;
    line_q.delete();
    n = smp.size();
    pkts_done++;
    assert (exp_lens.size() > 0 && n > EOP_LEN) else begin
      errors++;
      $display("packet %0d on the line was not expected or carried no bits", pkts_done);
    end
    if (exp_lens.size() == 0 || n <= EOP_LEN)
      return;
    for (int k = 0; k < EOP_LEN; k++)
      check_value("{dp,dm} during EOP", int'(smp[n - EOP_LEN + k]),
                  (k < usb_pkg::EOP_SE0_CYCLES) ? 0 : 2);
    prev   = 1'b1;
    same   = 0;
    ones   = 0;
    stuffs = 0;
    for (int i = 0; i < n - EOP_LEN; i++) begin
      assert (smp[i] == 2'b10 || smp[i] == 2'b01) else begin
        errors++;
        $display("ERR %0t {dp,dm}: got %b expected J or K", $time, smp[i]);
      end
      b    = (smp[i][1] == prev);
      same = (i > 0 && b) ? same + 1 : 1;
      prev = smp[i][1];
      // six ones hold one level for seven cycles at most
      assert (same != usb_pkg::STUFF_RUN + 2) else begin
        errors++;
        $display("line held one level too long in packet %0d", pkts_done);
      end
      if (i >= usb_pkg::SYNC_BITS && ones == usb_pkg::STUFF_RUN) begin
        check_value("stuffed bit", int'(b), 0);
        stuffs++;
        ones = 0;
      end else begin
        got.push_back(b);
        if (i >= usb_pkg::SYNC_BITS)
          ones = b ? ones + 1 : 0;
      end
    end
    assert (ones != usb_pkg::STUFF_RUN) else begin
      errors++;
      $display("packet %0d ends on a run of ones with no stuffed zero", pkts_done);
    end
    exp_len = exp_lens.pop_front();
    check_value("stuffed zero count", stuffs, exp_stuffs.pop_front());
    check_value("decoded bit count", got.size(), exp_len);
    for (int i = 0; i < exp_len; i++) begin
      b = exp_bits.pop_front();
      if (i < got.size())
        check_value($sformatf("packet %0d decoded bit %0d", pkts_done, i),
                    int'(got[i]), int'(b));
    end
  endtask

  // line monitor sampling mid-cycle
  always @(negedge clk) begin
    if (rst_L && pkt_valid && pkt_ready)
      accepts++;
    if (oe)
      line_q.push_back({dp, dm});
    else if (line_q.size() > 0)
      check_packet();
  end

  task automatic send_packet(input usb_pkg::pid_e pid,
                             input logic [usb_pkg::ADDR_W-1:0] addr,
                             input logic [usb_pkg::ENDP_W-1:0] endp,
                             input logic [DATA_W-1:0] data, input bit hold);
    bit up;
    build_expected(pid, addr, endp, data);
    pkt_valid = 1'b1;
    pkt_pid   = pid;
    pkt_addr  = addr;
    pkt_endp  = endp;
    pkt_data  = data;
    up        = 1'b0;
    for (int t = 0; t < TIMEOUT && !up; t++) begin
      if (pkt_ready)
        up = 1'b1;
      else
        next_cycle();
    end
    if (!up) begin
      timeouts++;
      pkt_valid = 1'b0;
      $display("timeout: pkt_ready never rose for packet %0d", sent);
      return;
    end
    // accepted on this edge, the serializer now holds the packet
    next_cycle();
    check_value("pkt_ready", int'(pkt_ready), 0);
    if (!hold)
      pkt_valid = 1'b0;
  endtask

  task automatic wait_done();
    int t;
    t = 0;
    if (timeouts > 0)
      return;
    while (pkts_done < sent && t < TIMEOUT) begin
      next_cycle();
      t++;
    end
    if (pkts_done < sent) begin
      timeouts++;
      $display("timeout: only %0d of %0d packets left the line", pkts_done, sent);
    end
  endtask

  task automatic test_reset_state();
    check_value("oe", int'(oe), 0);
    check_value("dp", int'(dp), 1);
    check_value("dm", int'(dm), 0);
    check_value("pkt_ready", int'(pkt_ready), 1);
  endtask

  task automatic test_handshake();
    send_packet(usb_pkg::PID_ACK, '0, '0, '0, 1'b0);
    wait_done();
  endtask

  task automatic test_tokens();
    send_packet(usb_pkg::PID_OUT, 7'h3a, 4'h5, '0, 1'b0);
    wait_done();
    // all ones in addr and endp forces a stuffed zero in the body
    send_packet(usb_pkg::PID_IN, 7'h7f, 4'hf, '0, 1'b0);
    wait_done();
  endtask

  task automatic test_data_ones();
    send_packet(usb_pkg::PID_DATA0, '0, '0, '1, 1'b0);
    wait_done();
  endtask

  task automatic test_back_to_back();
    int base;
    base = accepts;
    for (int i = 0; i < 3; i++) begin
      rng = xorshift(rng);
      send_packet(usb_pkg::PID_DATA0, '0, '0, rng, i < 2);
      if (timeouts > 0)
        return;
    end
    wait_done();
    check_value("packets accepted", accepts - base, 3);
  endtask

  initial begin
    checks    = 0;
    errors    = 0;
    timeouts  = 0;
    sent      = 0;
    pkts_done = 0;
    accepts   = 0;
    rng       = 64'd62;
    rst_L     = 1'b0;
    pkt_valid = 1'b0;
    pkt_pid   = usb_pkg::PID_ACK;
    pkt_addr  = '0;
    pkt_endp  = '0;
    pkt_data  = '0;
    repeat (2) @(posedge clk);
    #1;
    rst_L = 1'b1;
    test_reset_state();
    test_handshake();
    if (timeouts == 0)
      test_tokens();
    if (timeouts == 0)
      test_data_ones();
    if (timeouts == 0)
      test_back_to_back();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_usb_tx_assert.sv
/*
 * Line and handshake assertions for the USB transmit top level
 * Bound to usb_tx_top from the testbench
 */
`timescale 1ns/1ps
`default_nettype none

module tb_usb_tx_assert (
  input logic       clk,
  input logic       rst_L,
  input logic       pkt_valid,
  input logic       pkt_ready,
  input logic [7:0] pkt_pid,
  input logic       dp,
  input logic       dm,
  input logic       oe
);

  // SE1 is never a legal line state
  a_no_se1: assert property (@(posedge clk) disable iff (!rst_L) !(dp && dm))
    else $error("dp and dm are both high");

  // a waiting packet keeps its PID until accepted
  a_pid_hold: assert property (@(posedge clk) disable iff (!rst_L)
      (pkt_valid && !pkt_ready) |=> $stable(pkt_pid))
    else $error("pkt_pid changed while the packet was waiting");

  a_oe_after_reset: assert property (@(posedge clk) $rose(rst_L) |-> !oe)
    else $error("oe is high in the first cycle after reset");

endmodule

`default_nettype wire

//--- usb_tx_top.sv
/*
 * USB transmit top level
 * Packet port in, D+/D- out, through serializer, CRC appender,
 * bit stuffer and line driver
 */
`timescale 1ns/1ps
`default_nettype none

module usb_tx_top #(
  parameter int DATA_W = 64
) (
  input  logic                       clk,
  input  logic                       rst_L,
  input  logic                       pkt_valid,
  output logic                       pkt_ready,
  input  usb_pkg::pid_e              pkt_pid,
  input  logic [usb_pkg::ADDR_W-1:0] pkt_addr,
  input  logic [usb_pkg::ENDP_W-1:0] pkt_endp,
  input  logic [DATA_W-1:0]          pkt_data,
  output logic                       dp,
  output logic                       dm,
  output logic                       oe
);

  // links between the stages
  bit_stream_if ser_s ();
  bit_stream_if crc_s ();
  bit_stream_if stf_s ();

  usb_pkt_serializer #(
    .DATA_W (DATA_W)
  ) u_ser (
    .clk       (clk),
    .rst_L     (rst_L),
    .pkt_valid (pkt_valid),
    .pkt_ready (pkt_ready),
    .pkt_pid   (pkt_pid),
    .pkt_addr  (pkt_addr),
    .pkt_endp  (pkt_endp),
    .pkt_data  (pkt_data),
    .out       (ser_s)
  );

  usb_crc_append u_crc (
    .clk   (clk),
    .rst_L (rst_L),
    .in    (ser_s),
    .out   (crc_s)
  );

  usb_bit_stuffer u_stf (
    .clk   (clk),
    .rst_L (rst_L),
    .in    (crc_s),
    .out   (stf_s)
  );

  usb_line_driver u_drv (
    .clk   (clk),
    .rst_L (rst_L),
    .in    (stf_s),
    .dp    (dp),
    .dm    (dm),
    .oe    (oe)
  );

endmodule

`default_nettype wire

//--- usb_line_driver.sv
/*
 * USB line driver
 * NRZI-codes the stuffed stream onto D+/D- with an output enable and
 * closes every packet with SE0 cycles and one J cycle
 */
`timescale 1ns/1ps
`default_nettype none

module usb_line_driver (
  input  logic        clk,
  input  logic        rst_L,
  bit_stream_if.sink  in,
  output logic        dp,
  output logic        dm,
  output logic        oe
);

  localparam logic LEVEL_J = 1'b1;
  localparam int   SE0_W   = $clog2(usb_pkg::EOP_SE0_CYCLES + 1);
  localparam logic [SE0_W-1:0] SE0_LAST = SE0_W'(usb_pkg::EOP_SE0_CYCLES - 1);

  typedef enum logic [1:0] {IDLE, PACKET, SE0, EOPJ} state_e;

  state_e           state;
  logic             level_q;
  logic             base;
  logic             eop_pend;
  logic [SE0_W-1:0] se0_cnt;
  logic             in_xfer;

  assign in.ready = (state == IDLE) || (state == PACKET && !eop_pend);
  assign in_xfer  = in.valid && in.ready;

  // every packet starts coding from J
  assign base = (state == IDLE) ? LEVEL_J : level_q;

  always_comb begin
    oe = (state != IDLE);
    case (state)
      PACKET: begin
        dp = level_q;
        dm = ~level_q;
      end
      SE0: begin
        dp = 1'b0;
        dm = 1'b0;
      end
      default: begin
        dp = 1'b1;
        dm = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_L) begin
    if (!rst_L) begin
      state    <= IDLE;
      level_q  <= LEVEL_J;
      eop_pend <= 1'b0;
      se0_cnt  <= '0;
    end else begin
      if (in_xfer) begin
        // hold on a one, toggle on a zero
        level_q  <= in.data ? base : ~base;
        eop_pend <= in.last;
      end
      case (state)
        IDLE: if (in_xfer)
          state <= PACKET;
        PACKET: if (eop_pend) begin
          state    <= SE0;
          eop_pend <= 1'b0;
          se0_cnt  <= '0;
        end
        SE0: begin
          if (se0_cnt == SE0_LAST)
            state <= EOPJ;
          else
            se0_cnt <= se0_cnt + 1'b1;
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- usb_bit_stuffer.sv
/*
 * USB bit stuffer
 * Inserts a zero after a run of ones outside SYNC, stalling the
 * upstream link for the cycle of the inserted bit
 */
`timescale 1ns/1ps
`default_nettype none

module usb_bit_stuffer (
  input  logic          clk,
  input  logic          rst_L,
  bit_stream_if.sink    in,
  bit_stream_if.source  out
);

  localparam int RUN_W = $clog2(usb_pkg::STUFF_RUN + 1);
  localparam logic [RUN_W-1:0] RUN_FULL = RUN_W'(usb_pkg::STUFF_RUN);
  localparam logic [RUN_W-1:0] RUN_NEAR = RUN_W'(usb_pkg::STUFF_RUN - 1);

  logic [RUN_W-1:0]   run;
  logic               stuffing;
  logic               fills;
  logic               last_q;
  usb_pkg::bit_kind_e kind_q;
  logic               in_xfer;

  assign stuffing = (run == RUN_FULL);
  assign in.ready = out.ready && !stuffing;
  assign in_xfer  = in.valid && in.ready;

  // this bit completes a run, so a zero follows it
  assign fills = in.data && (in.kind != usb_pkg::BIT_SYNC) && (run == RUN_NEAR);

  always_comb begin
    if (stuffing) begin
      out.valid = 1'b1;
      out.data  = 1'b0;
      out.kind  = kind_q;
      out.last  = last_q;
    end else begin
      out.valid = in.valid;
      out.data  = in.data;
      out.kind  = in.kind;
      out.last  = in.last && !fills;
    end
  end

  always_ff @(posedge clk or negedge rst_L) begin
    if (!rst_L) begin
      run    <= '0;
      last_q <= 1'b0;
    end else if (stuffing) begin
      if (out.ready)
        run <= '0;
    end else if (in_xfer) begin
      run    <= (in.kind == usb_pkg::BIT_SYNC || !in.data) ? '0 : run + 1'b1;
      last_q <= in.last;
    end
  end

  // inserted zero carries the tag of the bit before it
  always_ff @(posedge clk) begin
    if (in_xfer)
      kind_q <= in.kind;
  end

endmodule

`default_nettype wire

//--- usb_crc_append.sv
/*
 * USB CRC appender
 * Passes stream bits through, runs CRC5 or CRC16 over the body bits and
 * appends the complemented CRC, MSB first, after the last body bit
 */
`timescale 1ns/1ps
`default_nettype none

module usb_crc_append (
  input  logic          clk,
  input  logic          rst_L,
  bit_stream_if.sink    in,
  bit_stream_if.source  out
);

  localparam int CW    = usb_pkg::CRC16_W;
  localparam int REM_W = $clog2(usb_pkg::CRC16_W);
  localparam logic [REM_W-1:0] CRC5_LAST  = REM_W'(usb_pkg::CRC5_W - 1);
  localparam logic [REM_W-1:0] CRC16_LAST = REM_W'(usb_pkg::CRC16_W - 1);
  // CRC5 runs in the low bits of the shared register
  localparam logic [CW-1:0] CRC_SEED =
    {usb_pkg::CRC16_INIT[CW-1:usb_pkg::CRC5_W], usb_pkg::CRC5_INIT};

  logic [CW-1:0]               crc_q;
  logic [CW-1:0]               crc16_nxt;
  logic [usb_pkg::CRC5_W-1:0]  crc5_nxt;
  logic                        emit;
  logic                        is16;
  logic [REM_W-1:0]            rem;
  logic                        body;
  logic                        in_xfer;

  assign body    = (in.kind == usb_pkg::BIT_CRC5_BODY) ||
                   (in.kind == usb_pkg::BIT_CRC16_BODY);
  assign in.ready = out.ready && !emit;
  assign in_xfer  = in.valid && in.ready;

  // shift left, fold in the polynomial when MSB xor input is set
  assign crc5_nxt  = {crc_q[usb_pkg::CRC5_W-2:0], 1'b0} ^
                     ((crc_q[usb_pkg::CRC5_W-1] ^ in.data) ? usb_pkg::CRC5_POLY : '0);
  assign crc16_nxt = {crc_q[CW-2:0], 1'b0} ^
                     ((crc_q[CW-1] ^ in.data) ? usb_pkg::CRC16_POLY : '0);

  always_comb begin
    if (emit) begin
      out.valid = 1'b1;
      out.data  = is16 ? ~crc_q[CW-1] : ~crc_q[usb_pkg::CRC5_W-1];
      out.kind  = usb_pkg::BIT_CRC;
      out.last  = (rem == '0);
    end else begin
      out.valid = in.valid;
      out.data  = in.data;
      out.kind  = in.kind;
      // the CRC now closes the packet
      out.last  = in.last && !body;
    end
  end

  always_ff @(posedge clk or negedge rst_L) begin
    if (!rst_L) begin
      emit <= 1'b0;
      is16 <= 1'b0;
      rem  <= '0;
    end else if (emit) begin
      if (out.ready) begin
        rem <= rem - 1'b1;
        if (rem == '0)
          emit <= 1'b0;
      end
    end else if (in_xfer && body) begin
      is16 <= (in.kind == usb_pkg::BIT_CRC16_BODY);
      if (in.last) begin
        emit <= 1'b1;
        rem  <= (in.kind == usb_pkg::BIT_CRC16_BODY) ? CRC16_LAST : CRC5_LAST;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (emit) begin
      if (out.ready)
        crc_q <= crc_q << 1;
    end else if (in_xfer) begin
      case (in.kind)
        usb_pkg::BIT_PID:        crc_q <= CRC_SEED;
        usb_pkg::BIT_CRC5_BODY:  crc_q <= {{(CW - usb_pkg::CRC5_W){1'b0}}, crc5_nxt};
        usb_pkg::BIT_CRC16_BODY: crc_q <= crc16_nxt;
        default:                 crc_q <= crc_q;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- usb_pkt_serializer.sv
/*
 * USB packet serializer
 * Loads one packet and emits SYNC, PID and the body that the PID selects,
 * one tagged bit per transfer, with registered outputs
 */
`timescale 1ns/1ps
`default_nettype none

module usb_pkt_serializer #(
  parameter int DATA_W = 64
) (
  input  logic                       clk,
  input  logic                       rst_L,
  input  logic                       pkt_valid,
  output logic                       pkt_ready,
  input  usb_pkg::pid_e              pkt_pid,
  input  logic [usb_pkg::ADDR_W-1:0] pkt_addr,
  input  logic [usb_pkg::ENDP_W-1:0] pkt_endp,
  input  logic [DATA_W-1:0]          pkt_data,
  bit_stream_if.source               out
);

  localparam int CNT_W = $clog2(DATA_W);
  localparam logic [CNT_W-1:0] SYNC_LAST = CNT_W'(usb_pkg::SYNC_BITS - 1);
  localparam logic [CNT_W-1:0] PID_LAST  = CNT_W'($bits(usb_pkg::pid_e) - 1);
  localparam logic [CNT_W-1:0] ADDR_LAST = CNT_W'(usb_pkg::ADDR_W - 1);
  localparam logic [CNT_W-1:0] ENDP_LAST = CNT_W'(usb_pkg::ENDP_W - 1);
  localparam logic [CNT_W-1:0] DATA_LAST = CNT_W'(DATA_W - 1);

  typedef enum logic [2:0] {IDLE, SYNC, PID, ADDR, ENDP, DATA} state_e;

  // state and cnt name the bit currently held on the output
  state_e                     state;
  state_e                     nxt_state;
  logic [CNT_W-1:0]           cnt;
  logic [CNT_W-1:0]           nxt_cnt;
  usb_pkg::pid_e              pid_q;
  logic [usb_pkg::ADDR_W-1:0] addr_q;
  logic [usb_pkg::ENDP_W-1:0] endp_q;
  logic [DATA_W-1:0]          data_q;
  logic                       nxt_bit;
  logic                       nxt_last;
  usb_pkg::bit_kind_e         nxt_kind;
  logic                       load;
  logic                       advance;

  assign pkt_ready = (state == IDLE);
  assign load      = pkt_valid && pkt_ready;
  assign advance   = out.valid && out.ready;

  // position of the bit that follows the current one
  always_comb begin
    nxt_state = state;
    nxt_cnt   = cnt + 1'b1;
    if (load) begin
      nxt_state = SYNC;
      nxt_cnt   = '0;
    end else begin
      case (state)
        SYNC: if (cnt == SYNC_LAST) begin
          nxt_state = PID;
          nxt_cnt   = '0;
        end
        PID: if (cnt == PID_LAST) begin
          nxt_cnt = '0;
          case (pid_q)
            usb_pkg::PID_OUT, usb_pkg::PID_IN: nxt_state = ADDR;
            usb_pkg::PID_DATA0:                nxt_state = DATA;
            default:                           nxt_state = IDLE;
          endcase
        end
        ADDR: if (cnt == ADDR_LAST) begin
          nxt_state = ENDP;
          nxt_cnt   = '0;
        end
        ENDP: if (cnt == ENDP_LAST) begin
          nxt_state = IDLE;
          nxt_cnt   = '0;
        end
        DATA: if (cnt == DATA_LAST) begin
          nxt_state = IDLE;
          nxt_cnt   = '0;
        end
        default: begin
          nxt_state = IDLE;
          nxt_cnt   = '0;
        end
      endcase
    end
  end

  // value and tag of that bit
  always_comb begin
    nxt_bit  = 1'b0;
    nxt_kind = usb_pkg::BIT_SYNC;
    nxt_last = 1'b0;
    case (nxt_state)
      SYNC: nxt_bit = (nxt_cnt == SYNC_LAST);
      PID: begin
        nxt_kind = usb_pkg::BIT_PID;
        nxt_bit  = pid_q[nxt_cnt[2:0]];
        // handshake packets end on the PID
        nxt_last = (nxt_cnt == PID_LAST) &&
                   !(pid_q inside {usb_pkg::PID_OUT, usb_pkg::PID_IN, usb_pkg::PID_DATA0});
      end
      ADDR: begin
        nxt_kind = usb_pkg::BIT_CRC5_BODY;
        nxt_bit  = addr_q[nxt_cnt[$clog2(usb_pkg::ADDR_W)-1:0]];
      end
      ENDP: begin
        nxt_kind = usb_pkg::BIT_CRC5_BODY;
        nxt_bit  = endp_q[nxt_cnt[$clog2(usb_pkg::ENDP_W)-1:0]];
        nxt_last = (nxt_cnt == ENDP_LAST);
      end
      DATA: begin
        nxt_kind = usb_pkg::BIT_CRC16_BODY;
        nxt_bit  = data_q[nxt_cnt];
        nxt_last = (nxt_cnt == DATA_LAST);
      end
      default: nxt_bit = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_L) begin
    if (!rst_L) begin
      state     <= IDLE;
      cnt       <= '0;
      out.valid <= 1'b0;
      out.data  <= 1'b0;
      out.kind  <= usb_pkg::BIT_SYNC;
      out.last  <= 1'b0;
    end else if (load || advance) begin
      state     <= nxt_state;
      cnt       <= nxt_cnt;
      out.valid <= (nxt_state != IDLE);
      out.data  <= nxt_bit;
      out.kind  <= nxt_kind;
      out.last  <= nxt_last;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      pid_q  <= pkt_pid;
      addr_q <= pkt_addr;
      endp_q <= pkt_endp;
      data_q <= pkt_data;
    end
  end

endmodule

`default_nettype wire

//--- bit_stream_if.sv
/*
 * Serial bit stream link
 * One tagged bit per valid/ready transfer, last marks the packet end
 */
`timescale 1ns/1ps
`default_nettype none

interface bit_stream_if;

  logic               valid;
  logic               ready;
  logic               data;
  logic               last;
  usb_pkg::bit_kind_e kind;

  modport source (output valid, data, kind, last, input ready);

  modport sink (input valid, data, kind, last, output ready);

endinterface

`default_nettype wire

//--- usb_pkg.sv
/*
 * USB transmit definitions
 * PID byte values, stream bit tags, field widths and CRC constants
 * shared by the transmit pipeline
 */
`default_nettype none

package usb_pkg;

  // PID bytes carry the check nibble in the upper half and go out LSB first
  typedef enum logic [7:0] {
    PID_OUT   = 8'b1110_0001,
    PID_IN    = 8'b0110_1001,
    PID_DATA0 = 8'b1100_0011,
    PID_ACK   = 8'b1101_0010,
    PID_NAK   = 8'b0101_1010
  } pid_e;

  // tag carried with every serial bit between stages
  typedef enum logic [2:0] {
    BIT_SYNC,
    BIT_PID,
    BIT_CRC5_BODY,
    BIT_CRC16_BODY,
    BIT_CRC
  } bit_kind_e;

  localparam int SYNC_BITS = 8;
  localparam int ADDR_W    = 7;
  localparam int ENDP_W    = 4;

  localparam int                 CRC5_W     = 5;
  localparam logic [CRC5_W-1:0]  CRC5_POLY  = 5'h05;
  localparam logic [CRC5_W-1:0]  CRC5_INIT  = '1;

  localparam int                 CRC16_W    = 16;
  localparam logic [CRC16_W-1:0] CRC16_POLY = 16'h8005;
  localparam logic [CRC16_W-1:0] CRC16_INIT = '1;

  // zero inserted after this many ones
  localparam int STUFF_RUN      = 6;
  localparam int EOP_SE0_CYCLES = 2;

endpackage

`default_nettype wire
